// File: build.f
design/mm_pkg.sv
design/operand_buffer.sv
design/operand_skew.sv
design/mac_array.sv
design/result_drain.sv
design/tile_ctrl.sv
design/mm_tile.sv
tb/mm_tile_assertions.sv
tb/tb_mm_tile.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mm_tile
FLIST     ?= build.f
SEED      ?= 7468
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

# the binary exits non-zero on $fatal or a failed assertion
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Gseed_init=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_mm_tile.sv
`timescale 1ns/1ps

module tb_mm_tile #(
    parameter int seed_init = 32'h1d2c
);

    localparam int timeout_cycles = 200;

    logic               clk;
    logic               rst_n;
    logic               in_req;
    mm_pkg::load_beat_t in_beat;
    logic               in_ack;
    logic               out_req;
    mm_pkg::acc_row_t   out_row;
    logic               out_ack;

    integer             seed;
    string              test_name;
    logic signed [mm_pkg::elem_w-1:0] mat_a [mm_pkg::tile_n][mm_pkg::tile_n];
    logic signed [mm_pkg::elem_w-1:0] mat_b [mm_pkg::tile_n][mm_pkg::tile_n];
    mm_pkg::load_beat_t beats [$];
    mm_pkg::acc_row_t   rows [$];    // expected rows, oldest first

    mm_tile u_mm_tile (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_beat (in_beat),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_row (out_row),
        .out_ack (out_ack)
    );

    always #2 clk = ~clk;

    task automatic halt_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    function automatic string row_text(input mm_pkg::acc_row_t r);
        return $sformatf("(%0d %0d %0d %0d)", r.c0, r.c1, r.c2, r.c3);
    endfunction

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        while (in_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                halt_run($sformatf("timeout waiting for in_ack to go %0b", level));
            end
        end
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        while (out_req !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                halt_run($sformatf("timeout waiting for out_req to go %0b", level));
            end
        end
    endtask

    task automatic fill_random();
        int r;
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            for (int j = 0; j < mm_pkg::tile_n; j++) begin
                r = $random(seed);
                mat_a[i][j] = r[7:0];
                mat_b[i][j] = r[15:8];
            end
        end
    endtask

    // beats for one job plus the reference product rows
    task automatic queue_job();
        mm_pkg::load_beat_t beat;
        logic [mm_pkg::tile_n-1:0][mm_pkg::acc_w-1:0] lanes;
        int sum;
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            beat.vec = {mat_a[i][3], mat_a[i][2], mat_a[i][1], mat_a[i][0]};   // A row i
            beats.push_back(beat);
        end
        for (int j = 0; j < mm_pkg::tile_n; j++) begin
            beat.vec = {mat_b[3][j], mat_b[2][j], mat_b[1][j], mat_b[0][j]};   // B column j
            beats.push_back(beat);
        end
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            for (int j = 0; j < mm_pkg::tile_n; j++) begin
                sum = 0;
                for (int k = 0; k < mm_pkg::tile_n; k++) begin
                    sum += mat_a[i][k] * mat_b[k][j];
                end
                lanes[j] = sum[mm_pkg::acc_w-1:0];
            end
            rows.push_back(mm_pkg::acc_row_t'(lanes));
        end
    endtask

    task automatic send_beats();
        while (beats.size() > 0) begin
            in_beat = beats.pop_front();
            in_req  = 1'b1;
            wait_in_ack(1'b1);
            @(negedge clk);                 // req held a cycle past ack
            in_req = 1'b0;
            wait_in_ack(1'b0);
        end
    endtask

    task automatic collect_rows();
        mm_pkg::acc_row_t want;
        mm_pkg::acc_row_t seen;
        int               delay;
        int               row_num;
        row_num = 0;
        while (rows.size() > 0) begin
            want = rows.pop_front();
            wait_out_req(1'b1);
            seen = out_row;
            assert (seen == want) else begin
                $display("FAIL %s row %0d: expected %s actual %s", test_name,
                         row_num % mm_pkg::tile_n, row_text(want), row_text(seen));
                halt_run("result row differs from the reference product");
            end
            delay = $unsigned($random(seed)) % 6;   // host back-pressure
            for (int d = 0; d < delay; d++) begin
                @(negedge clk);
                assert (out_req) else halt_run("out_req dropped before out_ack was raised");
                assert (out_row == want) else begin
                    $display("FAIL %s row %0d hold: expected %s actual %s", test_name,
                             row_num % mm_pkg::tile_n, row_text(want), row_text(out_row));
                    halt_run("out_row changed while out_req was high");
                end
            end
            out_ack = 1'b1;
            wait_out_req(1'b0);
            out_ack = 1'b0;
            row_num++;
        end
    endtask

    task automatic run_queued();
        fork
            send_beats();
            collect_rows();
        join
    endtask

    // ****************************************
    // test sequence
    // ****************************************
    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_beat = '0;
        out_ack = 1'b0;
        seed    = seed_init;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        assert (!in_ack && !out_req) else halt_run("in_ack or out_req high after reset");

        test_name = "identity";
        fill_random();
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            for (int j = 0; j < mm_pkg::tile_n; j++) begin
                mat_a[i][j] = (i == j) ? 8'sd1 : 8'sd0;
            end
        end
        queue_job();
        run_queued();

        test_name = "random";
        fill_random();
        queue_job();
        run_queued();

        test_name = "extremes";
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            for (int j = 0; j < mm_pkg::tile_n; j++) begin
                mat_a[i][j] = -8'sd128;
                mat_b[i][j] = -8'sd128;
            end
        end
        queue_job();
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            for (int j = 0; j < mm_pkg::tile_n; j++) begin
                mat_a[i][j] = ((i + j) % 2 == 1) ? 8'sd127 : -8'sd128;
                mat_b[i][j] = ((i * j) % 2 == 1) ? -8'sd128 : 8'sd127;
            end
        end
        queue_job();
        run_queued();

        // second job is offered while the first one drains
        test_name = "back_to_back";
        fill_random();
        queue_job();
        fill_random();
        queue_job();
        run_queued();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb/mm_tile_assertions.sv
`timescale 1ns/1ps

module mm_tile_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_req,
    input logic in_ack,
    input logic out_req,
    input logic out_ack,
    input logic acc_clr
);

    logic [2:0] rows_owed;   // rows of the running job not yet drained
    logic       out_ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows_owed <= '0;
            out_ack_q <= 1'b0;
        end else begin
            out_ack_q <= out_ack;
            if (acc_clr) begin
                rows_owed <= 3'(mm_pkg::tile_n);
            end else if (out_ack_q && !out_ack && rows_owed != '0) begin
                rows_owed <= rows_owed - 3'd1;   // one row handshake done
            end
        end
    end

    // ****************************************
    // input channel
    // ****************************************
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (!in_req && !in_ack) |=> !in_ack) else $error("in_ack rose without in_req");

    ack_waits_for_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (in_ack && in_req) |=> in_ack) else $error("in_ack fell while in_req still high");

    ack_held_off: assert property (@(posedge clk) disable iff (!rst_n)
        (rows_owed != '0) |-> !in_ack) else $error("in_ack given with rows still undrained");

    // ****************************************
    // output channel
    // ****************************************
    req_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && !out_ack) |=> out_req) else $error("out_req dropped before out_ack");

    req_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack)) else $error("out_req fell without out_ack");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!in_ack && !out_req)) else $error("handshake outputs high after reset");

endmodule

bind tile_ctrl mm_tile_assertions u_mm_tile_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .acc_clr (acc_clr)
);

// File: design/mm_tile.sv
`timescale 1ns/1ps

module mm_tile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_req,
    input  mm_pkg::load_beat_t  in_beat,
    output logic                in_ack,
    output logic                out_req,
    output mm_pkg::acc_row_t    out_row,
    input  logic                out_ack
);

    logic              buf_wr;
    logic              buf_sel_b;
    logic              zero_feed;
    logic              adv_en;
    logic              acc_clr;
    logic              drain_load;
    logic              drain_shift;
    mm_pkg::idx_t      step_idx;
    mm_pkg::elem_vec_t a_step;
    mm_pkg::elem_vec_t b_step;
    mm_pkg::elem_vec_t a_skew;
    mm_pkg::elem_vec_t b_skew;
    mm_pkg::acc_mat_t  acc;

    // ****************************************
    // control
    // ****************************************
    tile_ctrl u_tile_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .buf_wr      (buf_wr),
        .buf_sel_b   (buf_sel_b),
        .step_idx    (step_idx),
        .zero_feed   (zero_feed),
        .adv_en      (adv_en),
        .acc_clr     (acc_clr),
        .drain_load  (drain_load),
        .drain_shift (drain_shift)
    );

    // ****************************************
    // datapath
    // ****************************************
    operand_buffer u_operand_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .buf_wr    (buf_wr),
        .buf_sel_b (buf_sel_b),
        .in_beat   (in_beat),
        .step_idx  (step_idx),
        .zero_feed (zero_feed),
        .a_step    (a_step),
        .b_step    (b_step)
    );

    operand_skew u_skew_a (.clk(clk), .rst_n(rst_n), .en(adv_en), .din(a_step), .dout(a_skew));
    operand_skew u_skew_b (.clk(clk), .rst_n(rst_n), .en(adv_en), .din(b_step), .dout(b_skew));

    mac_array u_mac_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (adv_en),
        .acc_clr (acc_clr),
        .a_west  (a_skew),   // A rows enter from the west
        .b_north (b_skew),
        .acc     (acc)
    );

    result_drain u_result_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_load  (drain_load),
        .drain_shift (drain_shift),
        .acc         (acc),
        .out_row     (out_row)
    );

endmodule

// File: design/tile_ctrl.sv
`timescale 1ns/1ps

module tile_ctrl (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_req,
    output logic          in_ack,
    output logic          out_req,
    input  logic          out_ack,
    output logic          buf_wr,
    output logic          buf_sel_b,
    output mm_pkg::idx_t  step_idx,
    output logic          zero_feed,
    output logic          adv_en,
    output logic          acc_clr,
    output logic          drain_load,
    output logic          drain_shift
);

    typedef enum logic [1:0] {
        st_load,
        st_compute,
        st_present,
        st_wait
    } state_t;

    state_t        state;
    mm_pkg::beat_t beat_cnt;
    mm_pkg::cyc_t  cyc_cnt;
    mm_pkg::idx_t  row_cnt;
    logic          last_beat;
    logic          last_cyc;
    logic          last_row;

    assign last_beat = (beat_cnt == '0);  // counter wrapped, all 8 beats in
    assign last_cyc  = (cyc_cnt == mm_pkg::cyc_t'(mm_pkg::compute_cycles - 1));
    assign last_row  = (row_cnt == mm_pkg::idx_t'(mm_pkg::tile_n - 1));

    // ****************************************
    // datapath strobes
    // ****************************************
    assign buf_wr    = (state == st_load) && in_req && !in_ack;
    assign buf_sel_b = beat_cnt[mm_pkg::beat_w-1];
    assign adv_en    = (state == st_compute) && !acc_clr;
    assign zero_feed = !((state == st_compute) && (cyc_cnt < mm_pkg::cyc_t'(mm_pkg::tile_n)));
    // holds at the last step while the skew flushes
    assign step_idx  = zero_feed ? mm_pkg::idx_t'(mm_pkg::tile_n - 1)
                                 : mm_pkg::idx_t'(cyc_cnt);

    // ****************************************
    // sequencer and both handshakes
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_load;
            in_ack      <= 1'b0;
            out_req     <= 1'b0;
            acc_clr     <= 1'b0;
            drain_load  <= 1'b0;
            drain_shift <= 1'b0;
            beat_cnt    <= '0;
            cyc_cnt     <= '0;
            row_cnt     <= '0;
        end else begin
            case (state)
                st_load: begin
                    if (buf_wr) begin
                        in_ack   <= 1'b1;               // beat captured
                        beat_cnt <= beat_cnt + 1'b1;
                    end else if (in_ack && !in_req) begin
                        in_ack <= 1'b0;
                        if (last_beat) begin
                            state   <= st_compute;
                            acc_clr <= 1'b1;
                            cyc_cnt <= '0;
                        end
                    end
                end
                st_compute: begin
                    acc_clr <= 1'b0;
                    if (adv_en) begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                        if (last_cyc) begin
                            state      <= st_present;
                            drain_load <= 1'b1;
                            row_cnt    <= '0;
                        end
                    end
                end
                st_present: begin
                    drain_load  <= 1'b0;
                    drain_shift <= 1'b0;
                    if (drain_load || drain_shift) begin
                        out_req <= 1'b1;                // row now stable
                    end else if (out_req && out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_wait;
                    end
                end
                st_wait: begin
                    if (!out_ack) begin
                        if (last_row) begin
                            state <= st_load;           // ready for next job
                        end else begin
                            row_cnt     <= row_cnt + 1'b1;
                            drain_shift <= 1'b1;
                            state       <= st_present;
                        end
                    end
                end
                default: state <= st_load;
            endcase
        end
    end

endmodule

// File: design/result_drain.sv
`timescale 1ns/1ps

module result_drain (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              drain_load,
    input  logic              drain_shift,
    input  mm_pkg::acc_mat_t  acc,
    output mm_pkg::acc_row_t  out_row
);

    // row 0 in the low slot, leaves first
    mm_pkg::acc_row_t [mm_pkg::tile_n-1:0] shadow;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow <= '0;
        end else if (drain_load) begin
            shadow <= acc;                              // snapshot of the array
        end else if (drain_shift) begin
            // next row moves up, top slot empties
            shadow <= {mm_pkg::acc_row_t'('0), shadow[mm_pkg::tile_n-1:1]};
        end
    end

    assign out_row = shadow[0];

endmodule

// File: design/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               acc_clr,
    input  mm_pkg::elem_vec_t  a_west,
    input  mm_pkg::elem_vec_t  b_north,
    output mm_pkg::acc_mat_t   acc
);

    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] a_edge;
    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] b_edge;

    // pass registers and accumulators, indexed [row][col]
    logic signed [mm_pkg::elem_w-1:0] a_q   [mm_pkg::tile_n][mm_pkg::tile_n];
    logic signed [mm_pkg::elem_w-1:0] b_q   [mm_pkg::tile_n][mm_pkg::tile_n];
    logic signed [mm_pkg::acc_w-1:0]  acc_q [mm_pkg::tile_n][mm_pkg::tile_n];

    logic [mm_pkg::tile_n-1:0][mm_pkg::tile_n-1:0][mm_pkg::acc_w-1:0] acc_flat;

    assign a_edge = a_west;
    assign b_edge = b_north;

    for (genvar i = 0; i < mm_pkg::tile_n; i++) begin : g_row
        for (genvar j = 0; j < mm_pkg::tile_n; j++) begin : g_col
            logic signed [mm_pkg::elem_w-1:0]   a_in;
            logic signed [mm_pkg::elem_w-1:0]   b_in;
            logic signed [2*mm_pkg::elem_w-1:0] prod;

            if (j == 0) begin : g_a_edge
                assign a_in = a_edge[i];
            end else begin : g_a_pass
                assign a_in = a_q[i][j-1];              // from the west neighbour
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_edge[j];
            end else begin : g_b_pass
                assign b_in = b_q[i-1][j];              // from the north neighbour
            end

            assign prod = a_in * b_in;

            always_ff @(posedge clk) begin
                if (!rst_n || acc_clr) begin
                    acc_q[i][j] <= '0;
                    a_q[i][j]   <= '0;
                    b_q[i][j]   <= '0;
                end else if (en) begin
                    acc_q[i][j] <= acc_q[i][j]
                        + {{(mm_pkg::acc_w - 2*mm_pkg::elem_w){prod[2*mm_pkg::elem_w-1]}},
                           prod};
                    a_q[i][j]   <= a_in;                // eastward
                    b_q[i][j]   <= b_in;                // southward
                end
            end

            assign acc_flat[i][j] = acc_q[i][j];
        end
    end

    assign acc = acc_flat;

endmodule

// File: design/operand_skew.sv
`timescale 1ns/1ps

module operand_skew (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  mm_pkg::elem_vec_t  din,
    output mm_pkg::elem_vec_t  dout
);

    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] lane_in;
    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] lane_out;

    assign lane_in = din;

    // lane i is a chain of i+1 registers, so the wavefront leaves diagonally
    for (genvar i = 0; i < mm_pkg::tile_n; i++) begin : g_lane
        logic [mm_pkg::elem_w-1:0] stage [i+1];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int s = 0; s <= i; s++) begin
                    stage[s] <= '0;
                end
            end else if (en) begin
                stage[0] <= lane_in[i];                 // input -> chain
                for (int s = 1; s <= i; s++) begin
                    stage[s] <= stage[s-1];
                end
            end
        end

        assign lane_out[i] = stage[i];                  // chain tail
    end

    assign dout = lane_out;

endmodule

// File: design/operand_buffer.sv
`timescale 1ns/1ps

module operand_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   buf_wr,
    input  logic                   buf_sel_b,
    input  mm_pkg::load_beat_t     in_beat,
    input  mm_pkg::idx_t           step_idx,
    input  logic                   zero_feed,
    output mm_pkg::elem_vec_t      a_step,
    output mm_pkg::elem_vec_t      b_step
);

    // A kept by rows, B kept by columns
    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] a_mem [mm_pkg::tile_n];
    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] b_mem [mm_pkg::tile_n];

    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] a_lane;
    logic [mm_pkg::tile_n-1:0][mm_pkg::elem_w-1:0] b_lane;

    mm_pkg::idx_t wr_ptr;
    mm_pkg::idx_t wr_idx;
    logic         last_sel;

    // pointer restarts whenever the host switches from A to B or back
    assign wr_idx = (buf_sel_b != last_sel) ? '0 : wr_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            last_sel <= 1'b0;
        end else if (buf_wr) begin
            wr_ptr   <= wr_idx + 1'b1;
            last_sel <= buf_sel_b;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr) begin
            if (buf_sel_b) begin
                b_mem[wr_idx] <= in_beat.vec;
            end else begin
                a_mem[wr_idx] <= in_beat.vec;
            end
        end
    end

    // transposed read, lane i of A column k is a[i][k]
    always_comb begin
        for (int i = 0; i < mm_pkg::tile_n; i++) begin
            a_lane[i] = zero_feed ? '0 : a_mem[i][step_idx];
            b_lane[i] = zero_feed ? '0 : b_mem[i][step_idx];   // b[k][i]
        end
    end

    assign a_step = a_lane;
    assign b_step = b_lane;

endmodule

// File: design/mm_pkg.sv
package mm_pkg;

    // ****************************************
    // tile geometry
    // ****************************************
    localparam int tile_n        = 4;
    localparam int elem_w        = 8;
    localparam int acc_w         = 20;           // room for four 16b products
    localparam int idx_w         = $clog2(tile_n);
    localparam int beats_per_job = 2 * tile_n;   // A rows, then B columns
    localparam int beat_w        = $clog2(beats_per_job);

    // ****************************************
    // fixed latencies
    // ****************************************
    localparam int skew_lat       = tile_n;      // last lane of the skew
    // feed steps, skew, array diagonal, final accumulate
    localparam int compute_cycles = tile_n + skew_lat + 2 * tile_n - 2 + 1;
    localparam int cyc_w          = $clog2(compute_cycles);

    typedef logic [idx_w-1:0]  idx_t;
    typedef logic [beat_w-1:0] beat_t;
    typedef logic [cyc_w-1:0]  cyc_t;

    // lane 0 sits in the low bits
    typedef struct packed {
        logic signed [elem_w-1:0] e3;
        logic signed [elem_w-1:0] e2;
        logic signed [elem_w-1:0] e1;
        logic signed [elem_w-1:0] e0;
    } elem_vec_t;

    typedef struct packed {
        elem_vec_t vec;
    } load_beat_t;

    typedef struct packed {
        logic signed [acc_w-1:0] c3;
        logic signed [acc_w-1:0] c2;
        logic signed [acc_w-1:0] c1;
        logic signed [acc_w-1:0] c0;
    } acc_row_t;

    typedef struct packed {
        acc_row_t r3;
        acc_row_t r2;
        acc_row_t r1;
        acc_row_t r0;
    } acc_mat_t;

endpackage
